//--- Makefile
TOP := memSubsystemTb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

build:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
logic/memStagePkg.sv
logic/stageBuses.sv
logic/memAccessCheck.sv
logic/coprocessor0.sv
logic/dataMemory.sv
logic/memoryStage.sv
logic/writebackStage.sv
logic/memSubsystem.sv
test/clockGen.sv
test/memSubsystemTb.sv

//--- logic/coprocessor0.sv
module coprocessor0
    import memStagePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  memOp        op,
    input  logic [31:0] pc,
    input  logic [31:0] writeData,
    input  logic [4:0]  regNum,
    input  logic        inDelaySlot,
    input  logic [5:0]  hwInt,
    input  logic [4:0]  exc,
    output kernelCtrl   kernel,
    output logic [29:0] epc,
    output logic        excBranchDelay,
    output logic [31:0] readData
);

    // Status fields
    logic [5:0]  im;
    logic        exl;
    logic        ie;

    // Cause fields
    logic [5:0]  ip;
    logic [4:0]  excCode;
    logic        bd;

    logic [29:0] epcWord;

    logic [31:0] sr;
    logic [31:0] cause;
    logic        interrupt;
    logic        exception;
    logic        enter;

    assign sr    = {16'b0, im, 8'b0, exl, ie};
    assign cause = {bd, 15'b0, ip, 3'b0, excCode, 2'b00};

    assign interrupt = (|(im & hwInt)) && ie && !exl;
    assign exception = exc != excNone;
    assign enter     = interrupt || exception;

    // Decision goes out in the same cycle
    always_comb begin
        if (enter) begin
            kernel = kKernelEntry;
        end else if (op == opEret) begin
            kernel = kEret;
        end else begin
            kernel = kNone;
        end
    end

    assign excBranchDelay = enter && inDelaySlot;
    assign epc            = epcWord;

    always_comb begin
        readData = 32'b0;
        if (op == opMfc0) begin
            case (regNum)
                regSr:    readData = sr;
                regCause: readData = cause;
                regEpc:   readData = {epcWord, 2'b00};
                regPrId:  readData = prIdValue;
                default:  readData = 32'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im      <= 6'b111111;
            exl     <= 1'b0;
            ie      <= 1'b1;
            ip      <= 6'b0;
            excCode <= excNone;
            bd      <= 1'b0;
            epcWord <= textStartAddr[31:2];
        end else begin
            ip <= hwInt;
            if (enter) begin
                exl     <= 1'b1;
                excCode <= interrupt ? excInt : exc;
                bd      <= inDelaySlot;
                // Delay slot restarts at the branch
                epcWord <= inDelaySlot ? pc[31:2] - 30'd1 : pc[31:2];
            end else if (op == opEret) begin
                exl     <= 1'b0;
                excCode <= excNone;
                bd      <= 1'b0;
            end else if (op == opMtc0) begin
                if (regNum == regSr) begin
                    {im, exl, ie} <= {writeData[15:10], writeData[1], writeData[0]};
                end else if (regNum == regEpc) begin
                    epcWord <= writeData[31:2];
                end
            end
        end
    end

endmodule

//--- logic/dataMemory.sv
module dataMemory
    import memStagePkg::*;
(
    input logic clk,
    dataMemBus.dataMemory mem
);

    logic [31:0] ram [memWords];

    logic [29:0]            relWord;
    logic [memAddrBits-1:0] index;
    logic                   inRam;

    initial begin
        for (int i = 0; i < memWords; i++) begin
            ram[i] = 32'b0;
        end
    end

    assign relWord = mem.wordAddr - dataStartAddr[31:2];
    assign index   = relWord[memAddrBits-1:0];
    assign inRam   = relWord < 30'(memWords);

    // Per-byte write, only inside the RAM
    always_ff @(posedge clk) begin
        if (inRam) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.byteEnable[b]) begin
                    ram[index][b*8 +: 8] <= mem.writeData[b*8 +: 8];
                end
            end
        end
    end

    assign mem.readData = inRam ? ram[index] : 32'b0;

endmodule

//--- logic/memAccessCheck.sv
module memAccessCheck
    import memStagePkg::*;
(
    input  memOp        op,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    input  logic        enable,
    output logic [29:0] wordAddr,
    output logic [3:0]  byteEnable,
    output logic [31:0] writeData,
    output logic [1:0]  offset,
    output logic [4:0]  exc
);

    logic       inRange;
    logic       misaligned;
    logic [3:0] lanes;

    assign wordAddr = addr[31:2];
    assign offset   = addr[1:0];

    // Unsigned wrap keeps this a single compare for any start address
    assign inRange = (addr - dataStartAddr) < (dataEndAddr - dataStartAddr);

    always_comb begin
        misaligned = 1'b0;
        case (op)
            opLw, opSw: misaligned = addr[1:0] != 2'b00;
            opLh, opLhu, opSh: misaligned = addr[0];
            default: misaligned = 1'b0;
        endcase
    end

    // Lane enables and data placed in the addressed lane
    always_comb begin
        lanes     = 4'b0000;
        writeData = storeData;
        case (op)
            opSw: lanes = 4'b1111;
            opSh: begin
                lanes     = 4'b0011 << {addr[1], 1'b0};
                writeData = storeData << {addr[1], 4'b0000};
            end
            opSb: begin
                lanes     = 4'b0001 << addr[1:0];
                writeData = storeData << {addr[1:0], 3'b000};
            end
            default: lanes = 4'b0000;
        endcase
    end

    always_comb begin
        exc = excNone;
        if (isLoad(op) && (misaligned || !inRange)) begin
            exc = excAdEL;
        end else if (isStore(op) && (misaligned || !inRange)) begin
            exc = excAdES;
        end
    end

    // No write for a faulting store or while the controller holds memory off
    assign byteEnable = (enable && exc == excNone) ? lanes : 4'b0000;

endmodule

//--- logic/memStagePkg.sv
package memStagePkg;

    // Decoded memory and coprocessor operations from execute
    typedef enum logic [3:0] {
        opNone,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret
    } memOp;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kNone,
        kKernelEntry,
        kEret
    } kernelCtrl;

    // Cause codes
    localparam logic [4:0] excNone = 5'd0;
    localparam logic [4:0] excInt  = 5'd0;
    localparam logic [4:0] excAdEL = 5'd4;
    localparam logic [4:0] excAdES = 5'd5;

    // Address map
    localparam logic [31:0] dataStartAddr = 32'h0000_0000;
    localparam logic [31:0] dataEndAddr   = 32'h0000_3000;
    localparam logic [31:0] textStartAddr = 32'h0000_3000;
    localparam int memWords    = int'((dataEndAddr - dataStartAddr) >> 2);
    localparam int memAddrBits = $clog2(memWords);

    // CP0 register numbers
    localparam logic [4:0] regSr    = 5'd12;
    localparam logic [4:0] regCause = 5'd13;
    localparam logic [4:0] regEpc   = 5'd14;
    localparam logic [4:0] regPrId  = 5'd15;

    localparam logic [31:0] prIdValue = 32'h0001_8a20;

    function automatic logic isLoad(memOp op);
        return op inside {opLw, opLh, opLhu, opLb, opLbu};
    endfunction

    function automatic logic isStore(memOp op);
        return op inside {opSw, opSh, opSb};
    endfunction

endpackage

//--- logic/memSubsystem.sv
module memSubsystem
    import memStagePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  memOp        op,
    input  logic [31:0] pc,
    input  logic [4:0]  excIn,
    input  logic        inDelaySlot,
    input  logic [31:0] aluOut,
    input  logic [31:0] rtData,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  rdAddr,
    input  logic [4:0]  regWriteAddr,
    input  logic [31:0] regWriteDataIn,
    input  logic        stall,
    input  logic        clear,
    input  logic        disableMem,
    input  logic [5:0]  hwInt,
    output kernelCtrl   kernel,
    output logic [29:0] epc,
    output logic        excBranchDelay,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData,
    output logic [31:0] wbPc
);

    dataMemBus memBus ();
    memWbBus   stageReg ();

    memoryStage memStage (
        .clk            (clk),
        .reset          (reset),
        .op             (op),
        .pc             (pc),
        .excIn          (excIn),
        .inDelaySlot    (inDelaySlot),
        .aluOut         (aluOut),
        .rtData         (rtData),
        .rtAddr         (rtAddr),
        .rdAddr         (rdAddr),
        .regWriteAddr   (regWriteAddr),
        .regWriteDataIn (regWriteDataIn),
        .stall          (stall),
        .clear          (clear),
        .disableMem     (disableMem),
        .hwInt          (hwInt),
        .wbAddr         (wbAddr),
        .wbData         (wbData),
        .mem            (memBus.memoryStage),
        .wb             (stageReg.memoryStage),
        .kernel         (kernel),
        .epc            (epc),
        .excBranchDelay (excBranchDelay)
    );

    dataMemory ram (
        .clk (clk),
        .mem (memBus.dataMemory)
    );

    // Its result also feeds the store forwarding path
    writebackStage wbStage (
        .wb     (stageReg.writebackStage),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .wbPc   (wbPc)
    );

endmodule

//--- logic/memoryStage.sv
module memoryStage
    import memStagePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  memOp        op,
    input  logic [31:0] pc,
    input  logic [4:0]  excIn,
    input  logic        inDelaySlot,
    input  logic [31:0] aluOut,
    input  logic [31:0] rtData,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  rdAddr,
    input  logic [4:0]  regWriteAddr,
    input  logic [31:0] regWriteDataIn,
    input  logic        stall,
    input  logic        clear,
    input  logic        disableMem,
    input  logic [5:0]  hwInt,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    dataMemBus.memoryStage mem,
    memWbBus.memoryStage   wb,
    output kernelCtrl   kernel,
    output logic [29:0] epc,
    output logic        excBranchDelay
);

    logic [31:0] storeValue;
    logic [1:0]  accessOffset;
    logic [4:0]  accessExc;
    logic [4:0]  excMerged;
    logic [31:0] cp0Data;
    logic [31:0] writeValue;

    // Writeback result bypasses the stale rt value
    assign storeValue = (wbAddr == rtAddr && rtAddr != 5'd0) ? wbData : rtData;

    memAccessCheck accessCheck (
        .op         (op),
        .addr       (aluOut),
        .storeData  (storeValue),
        .enable     (!disableMem),
        .wordAddr   (mem.wordAddr),
        .byteEnable (mem.byteEnable),
        .writeData  (mem.writeData),
        .offset     (accessOffset),
        .exc        (accessExc)
    );

    // Earlier stages win
    assign excMerged = (excIn != excNone) ? excIn : accessExc;

    coprocessor0 cp0 (
        .clk            (clk),
        .reset          (reset),
        .op             (op),
        .pc             (pc),
        .writeData      (storeValue),
        .regNum         (rdAddr),
        .inDelaySlot    (inDelaySlot),
        .hwInt          (hwInt),
        .exc            (excMerged),
        .kernel         (kernel),
        .epc            (epc),
        .excBranchDelay (excBranchDelay),
        .readData       (cp0Data)
    );

    always_comb begin
        if (op == opMfc0) begin
            writeValue = cp0Data;
        end else if (isLoad(op)) begin
            writeValue = mem.readData;
        end else begin
            writeValue = regWriteDataIn;
        end
    end

    // MEM/WB register, clear beats stall
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wb.op           <= opNone;
            wb.pc           <= 32'b0;
            wb.memWord      <= 32'b0;
            wb.offset       <= 2'b00;
            wb.regWriteAddr <= 5'd0;
            wb.regWriteData <= 32'b0;
        end else if (!stall) begin
            wb.op           <= op;
            wb.pc           <= pc;
            wb.memWord      <= mem.readData;
            wb.offset       <= accessOffset;
            wb.regWriteAddr <= regWriteAddr;
            wb.regWriteData <= writeValue;
        end
    end

endmodule

//--- logic/stageBuses.sv
// Memory stage to data RAM
interface dataMemBus;
    logic [29:0] wordAddr;
    logic [31:0] writeData;
    logic [3:0]  byteEnable;
    logic [31:0] readData;

    modport memoryStage(output wordAddr, writeData, byteEnable, input readData);
    modport dataMemory(input wordAddr, writeData, byteEnable, output readData);
endinterface

// MEM/WB register contents
interface memWbBus
    import memStagePkg::*;
();
    memOp        op;
    logic [31:0] pc;
    logic [31:0] memWord;
    logic [1:0]  offset;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteData;

    modport memoryStage(output op, pc, memWord, offset, regWriteAddr, regWriteData);
    modport writebackStage(input op, pc, memWord, offset, regWriteAddr, regWriteData);
endinterface

//--- logic/writebackStage.sv
module writebackStage
    import memStagePkg::*;
(
    memWbBus.writebackStage wb,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData,
    output logic [31:0] wbPc
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;

    // Lane picked by the low address bits
    assign laneByte = wb.memWord[{wb.offset, 3'b000} +: 8];
    assign laneHalf = wb.offset[1] ? wb.memWord[31:16] : wb.memWord[15:0];

    always_comb begin
        case (wb.op)
            opLb:    wbData = {{24{laneByte[7]}}, laneByte};
            opLbu:   wbData = {24'b0, laneByte};
            opLh:    wbData = {{16{laneHalf[15]}}, laneHalf};
            opLhu:   wbData = {16'b0, laneHalf};
            default: wbData = wb.regWriteData;
        endcase
    end

    assign wbAddr = wb.regWriteAddr;
    assign wbPc   = wb.pc;

endmodule

//--- test/clockGen.sv
module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Held for three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- include/memRefModel.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Shadow copy of the data RAM
logic [31:0] refMem [memStagePkg::memWords];

// Shadow status register fields
logic [5:0]  refIm;
logic        refIe;
logic        refExl;

logic [31:0] rngState;

function automatic void refReset(logic [31:0] seed);
    for (int i = 0; i < memStagePkg::memWords; i++) begin
        refMem[i] = 32'b0;
    end
    refIm    = 6'b111111;
    refIe    = 1'b1;
    refExl   = 1'b0;
    // Zero would lock the generator
    rngState = (seed == 32'b0) ? 32'h2545_f491 : seed;
endfunction

// Xorshift32
function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

function automatic void refStore(memStagePkg::memOp op, logic [31:0] addr, logic [31:0] data);
    int idx;
    idx = int'((addr - memStagePkg::dataStartAddr) >> 2);
    case (op)
        memStagePkg::opSw: refMem[idx] = data;
        memStagePkg::opSh: refMem[idx][addr[1]*16 +: 16] = data[15:0];
        memStagePkg::opSb: refMem[idx][addr[1:0]*8 +: 8] = data[7:0];
        default: ;
    endcase
endfunction

function automatic logic [31:0] refLoad(memStagePkg::memOp op, logic [31:0] addr);
    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  byteVal;
    word    = refMem[int'((addr - memStagePkg::dataStartAddr) >> 2)];
    half    = word[addr[1]*16 +: 16];
    byteVal = word[addr[1:0]*8 +: 8];
    case (op)
        memStagePkg::opLh:  return {{16{half[15]}}, half};
        memStagePkg::opLhu: return {16'b0, half};
        memStagePkg::opLb:  return {{24{byteVal[7]}}, byteVal};
        memStagePkg::opLbu: return {24'b0, byteVal};
        default:            return word;
    endcase
endfunction

function automatic logic refIntPending(logic [5:0] hw);
    return (|(refIm & hw)) && refIe && !refExl;
endfunction

function automatic logic [31:0] refEpc(logic [31:0] pc, logic inDelay);
    return inDelay ? pc - 32'd4 : pc;
endfunction

`endif

//--- test/memSubsystemTb.sv
module memSubsystemTb
    import memStagePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "memRefModel.svh"

    localparam int numRandom = 200;
    // Directed sequences stay under 80 issues, reset and drain add a few
    localparam int cycleLimit = numRandom + 80 + 20;

    logic        clk;
    logic        reset;
    memOp        op;
    logic [31:0] pc;
    logic [4:0]  excIn;
    logic        inDelaySlot;
    logic [31:0] aluOut;
    logic [31:0] rtData;
    logic [4:0]  rtAddr;
    logic [4:0]  rdAddr;
    logic [4:0]  regWriteAddr;
    logic [31:0] regWriteDataIn;
    logic        stall;
    logic        clear;
    logic        disableMem;
    logic [5:0]  hwInt;
    kernelCtrl   kernel;
    logic [29:0] epc;
    logic        excBranchDelay;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic [31:0] wbPc;

    // Expected writeback outputs, oldest first
    string       nameQ[$];
    logic        knownQ[$];
    logic [4:0]  addrQ[$];
    logic [31:0] dataQ[$];
    logic [31:0] pcQ[$];
    string       entryName;
    logic        entryKnown;
    logic [4:0]  entryAddr;
    logic [31:0] entryData;
    logic [31:0] entryPc;

    // MEM/WB contents as seen by the op now in the memory stage
    logic [4:0]  modelAddr;
    logic [31:0] modelData;
    logic [31:0] modelPc;
    logic        modelKnown;

    // Cause and EPC shadow
    logic [4:0]  refCode;
    logic        refBd;
    logic [31:0] refEpcVal;
    logic [5:0]  prevHw;

    kernelCtrl   expKernel;
    logic        expBd;
    logic [29:0] expEpc;
    string       kernelName;
    logic        running;
    logic        holdNext;
    logic        flushNext;
    logic        disableNext;
    logic [4:0]  excNext;
    logic [31:0] pcNow;
    int          checkCount;
    int          errorCount;
    int          cycleCount = 0;

    clockGen clocks (.clk(clk), .reset(reset));

    memSubsystem UUT (.*);

    function automatic logic isLoadOp(memOp o);
        return o inside {opLw, opLh, opLhu, opLb, opLbu};
    endfunction

    function automatic logic isStoreOp(memOp o);
        return o inside {opSw, opSh, opSb};
    endfunction

    // Alignment by access size, then the 0x0000..0x2fff data window
    function automatic logic [4:0] accessFault(memOp o, logic [31:0] a);
        logic bad;
        bad = a >= dataEndAddr;
        if (o inside {opLw, opSw}) bad = bad || a[1:0] != 2'b00;
        if (o inside {opLh, opLhu, opSh}) bad = bad || a[0];
        if (isLoadOp(o) && bad) return excAdEL;
        if (isStoreOp(o) && bad) return excAdES;
        return excNone;
    endfunction

    // Expected MFC0 result
    function automatic logic [31:0] readCp0(logic [4:0] rd);
        case (rd)
            regSr:    return {16'b0, refIm, 8'b0, refExl, refIe};
            regCause: return {refBd, 15'b0, prevHw, 3'b0, refCode, 2'b00};
            regEpc:   return refEpcVal;
            regPrId:  return prIdValue;
            default:  return 32'b0;
        endcase
    endfunction

    function automatic void advanceCp0(memOp o, logic [4:0] rd, logic [31:0] value,
                                       logic delay, logic [4:0] fault, logic intr);
        if (intr || fault != excNone) begin
            refExl    = 1'b1;
            refCode   = intr ? excInt : fault;
            refBd     = delay;
            refEpcVal = refEpc(pcNow, delay);
        end else if (o == opEret) begin
            refExl  = 1'b0;
            refCode = excNone;
            refBd   = 1'b0;
        end else if (o == opMtc0 && rd == regSr) begin
            refIm  = value[15:10];
            refExl = value[1];
            refIe  = value[0];
        end else if (o == opMtc0 && rd == regEpc) begin
            refEpcVal = {value[31:2], 2'b00};
        end
    endfunction

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One op per cycle; expectations are worked out before driving
    task automatic issue(input memOp o, input logic [31:0] addr, input logic [31:0] rt,
                         input logic [4:0] rtA, input logic [4:0] rd, input logic [4:0] wa,
                         input logic [31:0] wd, input logic delay, input logic [5:0] hw,
                         input string name);
        logic [4:0]  fault;
        logic        intr;
        logic [31:0] storeVal;
        logic [31:0] result;
        @(posedge clk);
        // An exception from an earlier stage hides the access fault
        fault    = (excNext != excNone) ? excNext : accessFault(o, addr);
        intr     = refIntPending(hw);
        storeVal = (rtA != 5'd0 && rtA == modelAddr) ? modelData : rt;
        if (o == opMfc0) begin
            result = readCp0(rd);
        end else if (isLoadOp(o) && fault == excNone) begin
            result = refLoad(o, addr);
        end else begin
            result = wd;
        end
        expKernel  = (intr || fault != excNone) ? kKernelEntry : (o == opEret ? kEret : kNone);
        expBd      = (intr || fault != excNone) && delay;
        // EPC register still holds the state left by earlier ops
        expEpc     = refEpcVal[31:2];
        kernelName = name;
        running    = 1'b1;
        advanceCp0(o, rd, storeVal, delay, fault, intr);
        if (isStoreOp(o) && fault == excNone && !disableNext) begin
            refStore(o, addr, storeVal);
        end
        if (flushNext) begin
            modelAddr  = 5'd0;
            modelData  = 32'b0;
            modelPc    = 32'b0;
            modelKnown = 1'b1;
        end else if (!holdNext) begin
            modelAddr  = wa;
            modelData  = result;
            modelPc    = pcNow;
            modelKnown = !(isLoadOp(o) && fault != excNone);
        end
        nameQ.push_back(name);
        knownQ.push_back(modelKnown);
        addrQ.push_back(modelAddr);
        dataQ.push_back(modelData);
        pcQ.push_back(modelPc);
        op             <= o;
        pc             <= pcNow;
        excIn          <= excNext;
        inDelaySlot    <= delay;
        aluOut         <= addr;
        rtData         <= rt;
        rtAddr         <= rtA;
        rdAddr         <= rd;
        regWriteAddr   <= wa;
        regWriteDataIn <= wd;
        stall          <= holdNext;
        clear          <= flushNext;
        disableMem     <= disableNext;
        hwInt          <= hw;
        prevHw = hw;
        pcNow  = pcNow + 32'd4;
    endtask

    task automatic idle(input logic [4:0] wa, input logic [31:0] wd, input string name);
        issue(opNone, 32'b0, 32'b0, 5'd0, 5'd0, wa, wd, 1'b0, 6'd0, name);
    endtask

    task automatic load(input memOp o, input logic [31:0] addr, input logic [4:0] wa,
                        input string name);
        issue(o, addr, 32'b0, 5'd0, 5'd0, wa, 32'b0, 1'b0, 6'd0, name);
    endtask

    task automatic store(input memOp o, input logic [31:0] addr, input logic [31:0] data,
                         input logic [4:0] rtA, input string name);
        issue(o, addr, data, rtA, 5'd0, 5'd0, 32'b0, 1'b0, 6'd0, name);
    endtask

    task automatic moveFromCp0(input logic [4:0] rd, input string name);
        issue(opMfc0, 32'b0, 32'b0, 5'd0, rd, 5'd8, 32'b0, 1'b0, 6'd0, name);
    endtask

    task automatic moveToCp0(input logic [4:0] rd, input logic [31:0] value, input string name);
        issue(opMtc0, 32'b0, value, 5'd0, rd, 5'd0, 32'b0, 1'b0, 6'd0, name);
    endtask

    // Cause, EPC, then ERET and the status afterwards
    task automatic drainException(input string name);
        moveFromCp0(regCause, {name, " cause"});
        moveFromCp0(regEpc, {name, " epc"});
        issue(opEret, 32'b0, 32'b0, 5'd0, 5'd0, 5'd0, 32'b0, 1'b0, 6'd0, {name, " eret"});
        moveFromCp0(regSr, {name, " status"});
    endtask

    task automatic randomAccesses();
        logic [31:0] r;
        logic [31:0] addr;
        memOp        o;
        for (int i = 0; i < numRandom; i++) begin
            r = nextRandom();
            case (r[2:0])
                3'd0:    o = opSw;
                3'd1:    o = opSh;
                3'd2:    o = opSb;
                3'd3:    o = opLw;
                3'd4:    o = opLh;
                3'd5:    o = opLhu;
                3'd6:    o = opLb;
                default: o = opLbu;
            endcase
            // Two small windows so loads hit earlier stores
            addr = (r[6] ? 32'h0000_2f00 : 32'h0000_0100) + {24'b0, r[12:7], 2'b00};
            if (o inside {opSh, opLh, opLhu}) addr = addr + {30'b0, r[13], 1'b0};
            if (o inside {opSb, opLb, opLbu}) addr = addr + {30'b0, r[14:13]};
            if (isStoreOp(o)) begin
                store(o, addr, nextRandom(), 5'd0, "random store");
            end else begin
                load(o, addr, r[19:15], "random load");
            end
        end
    endtask

    task automatic forwarding();
        idle(5'd5, 32'hcafe_f00d, "forward source");
        store(opSw, 32'h0000_0300, 32'h1111_1111, 5'd5, "forwarded sw");
        load(opLw, 32'h0000_0300, 5'd6, "load forwarded word");
        store(opSb, 32'h0000_0304, 32'h0000_0000, 5'd6, "forwarded sb from load");
        load(opLbu, 32'h0000_0304, 5'd7, "load forwarded byte");
        store(opSw, 32'h0000_0308, 32'h2222_2222, 5'd9, "sw without match");
        load(opLw, 32'h0000_0308, 5'd10, "load unforwarded word");
    endtask

    task automatic stallAndClear();
        idle(5'd7, 32'h1234_5678, "before stall");
        holdNext = 1'b1;
        idle(5'd9, 32'hdead_beef, "stall 1");
        idle(5'd9, 32'hdead_beef, "stall 2");
        holdNext = 1'b0;
        idle(5'd9, 32'hdead_beef, "after stall");
        holdNext  = 1'b1;
        flushNext = 1'b1;
        idle(5'd11, 32'h0bad_f00d, "clear over stall");
        holdNext  = 1'b0;
        flushNext = 1'b0;
        idle(5'd12, 32'h0000_0042, "after clear");
        disableNext = 1'b1;
        store(opSw, 32'h0000_0400, 32'h0000_0077, 5'd0, "store with memory disabled");
        disableNext = 1'b0;
        load(opLw, 32'h0000_0400, 5'd13, "load after disabled store");
    endtask

    task automatic addressFaults();
        load(opLw, 32'h0000_0102, 5'd3, "misaligned lw");
        drainException("misaligned lw");
        store(opSw, 32'h0000_0200, 32'h5555_aaaa, 5'd0, "sw before faulting sh");
        issue(opSh, 32'h0000_0201, 32'h0000_abcd, 5'd0, 5'd0, 5'd0, 32'b0, 1'b1, 6'd0,
              "misaligned sh in delay slot");
        drainException("misaligned sh");
        load(opLw, 32'h0000_0200, 5'd4, "word after faulting sh");
        load(opLh, 32'h0000_3000, 5'd3, "lh out of range");
        drainException("lh out of range");
        issue(opSb, 32'hffff_fff0, 32'h0000_0011, 5'd0, 5'd0, 5'd0, 32'b0, 1'b1, 6'd0,
              "sb out of range in delay slot");
        drainException("sb out of range");
        // Reserved instruction code from execute on a misaligned store
        excNext = 5'd10;
        store(opSh, 32'h0000_0203, 32'h0000_1234, 5'd0, "incoming exception over AdES");
        excNext = excNone;
        drainException("incoming exception");
    endtask

    task automatic interruptMasking();
        moveToCp0(regSr, 32'h0000_0001, "mask all lines");
        issue(opNone, 32'b0, 32'b0, 5'd0, 5'd0, 5'd0, 32'b0, 1'b0, 6'b000100, "masked irq");
        moveToCp0(regSr, 32'h0000_fc00, "interrupts disabled");
        issue(opNone, 32'b0, 32'b0, 5'd0, 5'd0, 5'd0, 32'b0, 1'b0, 6'b000100, "irq with IE off");
        moveToCp0(regSr, 32'h0000_1001, "line 2 enabled");
        issue(opNone, 32'b0, 32'b0, 5'd0, 5'd0, 5'd0, 32'b0, 1'b1, 6'b000100, "irq taken");
        issue(opNone, 32'b0, 32'b0, 5'd0, 5'd0, 5'd0, 32'b0, 1'b0, 6'b000100, "irq under EXL");
        drainException("interrupt");
        moveToCp0(regSr, 32'h0000_fc01, "restore status");
    endtask

    task automatic cp0Registers();
        moveToCp0(regEpc, 32'h0000_1234, "write EPC");
        moveFromCp0(regEpc, "read EPC");
        moveFromCp0(regPrId, "read PrID");
        moveFromCp0(5'd3, "read unmapped register");
    endtask

    // Kernel decision in the current cycle, writeback of the previous issue
    always @(negedge clk) begin
        if (running) begin
            expectEqual({kernelName, " kernel"}, 32'(expKernel), 32'(kernel));
            expectEqual({kernelName, " branch delay"}, 32'(expBd), 32'(excBranchDelay));
            expectEqual({kernelName, " epc"}, 32'(expEpc), 32'(epc));
        end
        if (nameQ.size() >= 2) begin
            entryName  = nameQ.pop_front();
            entryKnown = knownQ.pop_front();
            entryAddr  = addrQ.pop_front();
            entryData  = dataQ.pop_front();
            entryPc    = pcQ.pop_front();
            if (entryKnown) begin
                expectEqual({entryName, " wbAddr"}, 32'(entryAddr), 32'(wbAddr));
                expectEqual({entryName, " wbData"}, entryData, wbData);
                expectEqual({entryName, " wbPc"}, entryPc, wbPc);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        op             = opNone;
        pc             = 32'b0;
        excIn          = excNone;
        inDelaySlot    = 1'b0;
        aluOut         = 32'b0;
        rtData         = 32'b0;
        rtAddr         = 5'd0;
        rdAddr         = 5'd0;
        regWriteAddr   = 5'd0;
        regWriteDataIn = 32'b0;
        stall          = 1'b0;
        clear          = 1'b0;
        disableMem     = 1'b0;
        hwInt          = 6'd0;
        holdNext       = 1'b0;
        flushNext      = 1'b0;
        disableNext    = 1'b0;
        excNext        = excNone;
        running        = 1'b0;
        modelAddr      = 5'd0;
        modelData      = 32'b0;
        modelPc        = 32'b0;
        modelKnown     = 1'b1;
        refCode        = excNone;
        refBd          = 1'b0;
        refEpcVal      = textStartAddr;
        expEpc         = textStartAddr[31:2];
        prevHw         = 6'd0;
        pcNow          = 32'h0000_3000;
        checkCount     = 0;
        errorCount     = 0;
        refReset(32'hd66e_296d);
        @(negedge reset);
        randomAccesses();
        forwarding();
        stallAndClear();
        addressFaults();
        interruptMasking();
        cp0Registers();
        idle(5'd0, 32'b0, "drain 1");
        idle(5'd0, 32'b0, "drain 2");
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
